// File: fft_pkg.sv
`default_nettype none

package fft_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // transform geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int n_samples = 8;                // complex samples per frame.
  localparam int log_n = 3;                    // number of radix-2 stages.
  localparam int n_pairs = n_samples / 2;      // butterflies per stage.
  localparam int tw_bits = log_n - 1;          // width of a twiddle exponent.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // number format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int data_width = 32;
  localparam int frac_bits = 16;               // Q16.16 fixed point.

  // one real or imaginary part.
  typedef logic signed [data_width-1:0] sample_t;

  typedef logic [1:0] stage_t;                 // stage index, 0 to log_n - 1.

  typedef enum logic [1:0] {
    st_idle,                                   // waiting for a frame.
    st_comp,                                   // one stage per cycle.
    st_done                                    // result offered downstream.
  } fft_state_t;

endpackage

`default_nettype wire

// File: fft_twiddle_rom.sv
`timescale 1ns/100ps
`default_nettype none

module fft_twiddle_rom (
  input  wire fft_pkg::stage_t  stage,
  output fft_pkg::sample_t      tw_re [fft_pkg::n_pairs],
  output fft_pkg::sample_t      tw_im [fft_pkg::n_pairs]
);

  import fft_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // W^k = cos(2*pi*k/8) - j*sin(2*pi*k/8), k = 0 to 3
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam sample_t one = sample_t'(1) <<< frac_bits;
  localparam sample_t root_half = sample_t'(46341);  // 0.70710678 rounded.
  localparam sample_t zero = sample_t'(0);

  localparam sample_t cos_tab [n_pairs] = '{one, root_half, zero, -root_half};
  localparam sample_t nsin_tab [n_pairs] = '{zero, -root_half, -one, -root_half};

  logic [tw_bits-1:0] tw_mask;

  // stage 0 keeps no bits of the pair index, the last stage keeps them all.
  assign tw_mask = ~({tw_bits{1'b1}} >> stage);

  for (genvar p = 0; p < n_pairs; p++) begin : g_pair
    logic [tw_bits-1:0] k;

    assign k = tw_bits'(p) & tw_mask;          // Pease exponent of pair p.
    assign tw_re[p] = cos_tab[k];
    assign tw_im[p] = nsin_tab[k];
  end

endmodule

`default_nettype wire

// File: fft_butterfly.sv
`timescale 1ns/100ps
`default_nettype none

module fft_butterfly (
  input  wire fft_pkg::sample_t  a_re,
  input  wire fft_pkg::sample_t  a_im,
  input  wire fft_pkg::sample_t  b_re,
  input  wire fft_pkg::sample_t  b_im,
  input  wire fft_pkg::sample_t  w_re,
  input  wire fft_pkg::sample_t  w_im,
  output fft_pkg::sample_t       c_re,
  output fft_pkg::sample_t       c_im,
  output fft_pkg::sample_t       d_re,
  output fft_pkg::sample_t       d_im
);

  import fft_pkg::*;

  logic signed [2*data_width-1:0] prod_rr;
  logic signed [2*data_width-1:0] prod_ii;
  logic signed [2*data_width-1:0] prod_ri;
  logic signed [2*data_width-1:0] prod_ir;
  logic signed [2*data_width-1:0] t_re_full;
  logic signed [2*data_width-1:0] t_im_full;
  sample_t t_re;
  sample_t t_im;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // complex multiply t = b * w
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign prod_rr = b_re * w_re;                 // full Q32.32 products.
  assign prod_ii = b_im * w_im;
  assign prod_ri = b_re * w_im;
  assign prod_ir = b_im * w_re;

  assign t_re_full = prod_rr - prod_ii;
  assign t_im_full = prod_ri + prod_ir;

  // back to Q16.16, the upper bits simply drop off.
  assign t_re = sample_t'(t_re_full >>> frac_bits);
  assign t_im = sample_t'(t_im_full >>> frac_bits);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sum and difference
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign c_re = a_re + t_re;
  assign c_im = a_im + t_im;
  assign d_re = a_re - t_re;                    // wraps on overflow.
  assign d_im = a_im - t_im;

endmodule

`default_nettype wire

// File: fft_stage_exec.sv
`timescale 1ns/100ps
`default_nettype none

module fft_stage_exec (
  input  wire fft_pkg::sample_t bank_re  [fft_pkg::n_samples],
  input  wire fft_pkg::sample_t bank_im  [fft_pkg::n_samples],
  input  wire fft_pkg::sample_t tw_re    [fft_pkg::n_pairs],
  input  wire fft_pkg::sample_t tw_im    [fft_pkg::n_pairs],
  output fft_pkg::sample_t      stage_re [fft_pkg::n_samples],
  output fft_pkg::sample_t      stage_im [fft_pkg::n_samples]
);

  import fft_pkg::*;

  sample_t bf_re [n_samples];                   // butterfly outputs, pair order.
  sample_t bf_im [n_samples];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one row of butterflies on adjacent samples
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar p = 0; p < n_pairs; p++) begin : g_bfly
    fft_butterfly fft_butterfly_inst (
      .a_re(bank_re[2*p]),
      .a_im(bank_im[2*p]),
      .b_re(bank_re[2*p+1]),
      .b_im(bank_im[2*p+1]),
      .w_re(tw_re[p]),
      .w_im(tw_im[p]),
      .c_re(bf_re[2*p]),
      .c_im(bf_im[2*p]),
      .d_re(bf_re[2*p+1]),
      .d_im(bf_im[2*p+1])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stride permutation
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the two outputs of butterfly p land at p and p + n/2, so the next
  // stage finds its partners adjacent again.
  for (genvar j = 0; j < n_samples; j++) begin : g_perm
    localparam int dest = (j % 2) * n_pairs + j / 2;

    assign stage_re[dest] = bf_re[j];
    assign stage_im[dest] = bf_im[j];
  end

endmodule

`default_nettype wire

// File: fft_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module fft_sequencer (
  input  wire              clk,
  input  wire              reset,
  input  wire              recv_val,
  input  wire              send_rdy,
  output logic             recv_rdy,
  output logic             send_val,
  output logic             load,
  output logic             compute,
  output fft_pkg::stage_t  stage
);

  import fft_pkg::*;

  localparam stage_t last_stage = stage_t'(log_n - 1);

  fft_state_t state;
  fft_state_t state_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (recv_val) state_next = st_comp;
      st_comp: if (stage == last_stage) state_next = st_done;
      st_done: begin
        if (send_rdy) begin
          state_next = recv_val ? st_comp : st_idle;  // back to back if offered.
        end
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      stage <= '0;
    end else begin
      state <= state_next;
      if (state == st_comp) begin
        stage <= (stage == last_stage) ? '0 : stage + 1'b1;
      end
    end
  end

  assign recv_rdy = (state == st_idle) || (state == st_done);
  assign send_val = (state == st_done);
  assign compute = (state == st_comp);

  // in st_done the bank is only overwritten once the result has left.
  assign load = (state == st_idle) || (state == st_done && recv_val && send_rdy);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_stage_range: assert property (@(posedge clk) disable iff (reset)
    stage <= last_stage);

  a_no_handshake_in_comp: assert property (@(posedge clk) disable iff (reset)
    compute |-> !recv_rdy && !send_val);

  // a result offered downstream is not withdrawn under back-pressure.
  a_send_val_held: assert property (@(posedge clk) disable iff (reset)
    send_val && !send_rdy |=> send_val);

endmodule

`default_nettype wire

// File: fft_sample_bank.sv
`timescale 1ns/100ps
`default_nettype none

module fft_sample_bank (
  input  wire clk,
  input  wire reset,
  input  wire load,
  input  wire compute,
  input  wire fft_pkg::sample_t recv_re  [fft_pkg::n_samples],
  input  wire fft_pkg::sample_t recv_im  [fft_pkg::n_samples],
  input  wire fft_pkg::sample_t stage_re [fft_pkg::n_samples],
  input  wire fft_pkg::sample_t stage_im [fft_pkg::n_samples],
  output fft_pkg::sample_t      bank_re  [fft_pkg::n_samples],
  output fft_pkg::sample_t      bank_im  [fft_pkg::n_samples]
);

  import fft_pkg::*;

  // reverses the log_n low bits of a sample index.
  function automatic int bit_rev(input int idx);
    int r;
    r = 0;
    for (int b = 0; b < log_n; b++) begin
      r = (r << 1) | ((idx >> b) & 1);
    end
    return r;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // frame registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    for (int i = 0; i < n_samples; i++) begin
      if (reset) begin
        bank_re[i] <= '0;
        bank_im[i] <= '0;
      end else if (load) begin
        bank_re[i] <= recv_re[bit_rev(i)];      // enter in bit-reversed order.
        bank_im[i] <= recv_im[bit_rev(i)];
      end else if (compute) begin
        bank_re[i] <= stage_re[i];
        bank_im[i] <= stage_im[i];
      end
    end
  end

  // the sequencer must never ask for a load in the middle of a transform.
  a_load_xor_compute: assert property (@(posedge clk) disable iff (reset)
    !(load && compute));

endmodule

`default_nettype wire

// File: fft_pease_top.sv
`timescale 1ns/100ps
`default_nettype none

module fft_pease_top (
  input  wire                   clk,
  input  wire                   reset,

  input  wire fft_pkg::sample_t recv_re [fft_pkg::n_samples],
  input  wire fft_pkg::sample_t recv_im [fft_pkg::n_samples],
  input  wire                   recv_val,
  output logic                  recv_rdy,

  output fft_pkg::sample_t      send_re [fft_pkg::n_samples],
  output fft_pkg::sample_t      send_im [fft_pkg::n_samples],
  output logic                  send_val,
  input  wire                   send_rdy
);

  import fft_pkg::*;

  logic load;
  logic compute;
  stage_t stage;

  sample_t tw_re [n_pairs];
  sample_t tw_im [n_pairs];
  sample_t bank_re [n_samples];                 // current frame, also the result.
  sample_t bank_im [n_samples];
  sample_t stage_re [n_samples];
  sample_t stage_im [n_samples];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode, execute and result blocks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  fft_sequencer fft_sequencer_inst (
    .clk(clk),
    .reset(reset),
    .recv_val(recv_val),
    .send_rdy(send_rdy),
    .recv_rdy(recv_rdy),
    .send_val(send_val),
    .load(load),
    .compute(compute),
    .stage(stage)
  );

  fft_twiddle_rom fft_twiddle_rom_inst (
    .stage(stage),
    .tw_re(tw_re),
    .tw_im(tw_im)
  );

  fft_stage_exec fft_stage_exec_inst (
    .bank_re(bank_re),
    .bank_im(bank_im),
    .tw_re(tw_re),
    .tw_im(tw_im),
    .stage_re(stage_re),
    .stage_im(stage_im)
  );

  fft_sample_bank fft_sample_bank_inst (
    .clk(clk),
    .reset(reset),
    .load(load),
    .compute(compute),
    .recv_re(recv_re),
    .recv_im(recv_im),
    .stage_re(stage_re),
    .stage_im(stage_im),
    .bank_re(bank_re),
    .bank_im(bank_im)
  );

  // after the last stage the bank holds the bins in natural order.
  assign send_re = bank_re;
  assign send_im = bank_im;

endmodule

`default_nettype wire

// File: fft_tb_vectors.svh
  localparam int n_cases = 10;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input frames in real units, one row per case, samples 0 to 7
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  real frame_re [n_cases][n_samples] = '{
    '{1.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0},                      // impulse at 0.
    '{1.5, 1.5, 1.5, 1.5, 1.5, 1.5, 1.5, 1.5},                      // constant.
    '{1.0, 0.70711, 0.0, -0.70711, -1.0, -0.70711, 0.0, 0.70711},   // cosine, bin 1.
    '{1.0, 0.0, -1.0, 0.0, 1.0, 0.0, -1.0, 0.0},                    // cosine, bin 2.
    '{1.0, -0.70711, 0.0, 0.70711, -1.0, 0.70711, 0.0, -0.70711},   // tone at bin 3.
    '{0.0, 1.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0},                      // sample 1 only.
    '{0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0},
    '{0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0},
    '{0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0},
    '{0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0}
  };

  real frame_im [n_cases][n_samples] = '{
    '{0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0},
    '{-0.5, -0.5, -0.5, -0.5, -0.5, -0.5, -0.5, -0.5},
    '{0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0},
    '{0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0},
    '{0.0, 0.70711, -1.0, 0.70711, 0.0, -0.70711, 1.0, -0.70711},
    '{0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0},
    '{0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0},
    '{0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0},
    '{0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0},
    '{0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0, 0.0}
  };

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per case controls
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // cycles that send_rdy stays low after the result appears.
  int hold_off [n_cases] = '{0, 2, 0, 3, 0, 5, 1, 0, 4, 2};

  // random rows ignore the frame tables above.
  bit use_random [n_cases] = '{
    1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
    1'b0, 1'b1, 1'b1, 1'b1, 1'b1
  };

// File: fft_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fft_tb;

  import fft_pkg::*;

  localparam int clk_period = 40;
  localparam int reset_cycles = 8;
  localparam int rand_limit = 4 << frac_bits;   // random parts stay within 4.0.
  localparam real lsb = 1.0 / 65536.0;
  localparam real pi = 3.14159265358979;

  `include "fft_tb_vectors.svh"

  logic clk = 1'b0;
  logic reset;
  logic recv_val;
  logic recv_rdy;
  logic send_val;
  logic send_rdy;
  sample_t recv_re [n_samples];
  sample_t recv_im [n_samples];
  sample_t send_re [n_samples];
  sample_t send_im [n_samples];

  sample_t in_re [n_cases][n_samples];          // frames as driven, Q16.16.
  sample_t in_im [n_cases][n_samples];
  sample_t held_re [n_samples];
  sample_t held_im [n_samples];
  real exp_re [n_samples];
  real exp_im [n_samples];
  real tol;
  integer seed;
  bit offered;

  always #(clk_period / 2) clk = ~clk;

  fft_pease_top fft_pease_top_inst (
    .clk(clk),
    .reset(reset),
    .recv_re(recv_re),
    .recv_im(recv_im),
    .recv_val(recv_val),
    .recv_rdy(recv_rdy),
    .send_re(send_re),
    .send_im(send_im),
    .send_val(send_val),
    .send_rdy(send_rdy)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_value(input real got, input real expected, input real limit,
                             input string what);
    if (got > expected + limit || got < expected - limit) begin
      $display("MISMATCH at %0d ns: %s, got %f, expected %f", $time, what, got, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic prepare_frames();
    for (int c = 0; c < n_cases; c++) begin
      for (int i = 0; i < n_samples; i++) begin
        if (use_random[c]) begin
          in_re[c][i] = $random(seed) % rand_limit;
          in_im[c][i] = $random(seed) % rand_limit;
        end else begin
          in_re[c][i] = $rtoi(frame_re[c][i] * 65536.0);
          in_im[c][i] = $rtoi(frame_im[c][i] * 65536.0);
        end
      end
    end
  endtask

  // direct DFT of the driven frame, X[k] = sum of x[n] * exp(-j*2*pi*k*n/8).
  task automatic compute_reference(input int c);
    real theta;
    real xr;
    real xi;
    real peak;
    peak = 1.0;
    for (int k = 0; k < n_samples; k++) begin
      exp_re[k] = 0.0;
      exp_im[k] = 0.0;
      for (int n = 0; n < n_samples; n++) begin
        theta = 2.0 * pi * real'(k * n) / real'(n_samples);
        xr = $itor(in_re[c][n]) * lsb;
        xi = $itor(in_im[c][n]) * lsb;
        exp_re[k] += xr * $cos(theta) + xi * $sin(theta);
        exp_im[k] += xi * $cos(theta) - xr * $sin(theta);
        if (xr > peak || -xr > peak) peak = (xr < 0.0) ? -xr : xr;
        if (xi > peak || -xi > peak) peak = (xi < 0.0) ? -xi : xi;
      end
    end
    tol = 8.0 * lsb * peak;
  endtask

  task automatic offer_frame(input int c);
    for (int i = 0; i < n_samples; i++) begin
      recv_re[i] <= in_re[c][i];
      recv_im[i] <= in_im[c][i];
    end
    recv_val <= 1'b1;
  endtask

  task automatic run_case(input int c);
    int cycles;
    do @(posedge clk); while (!recv_rdy);        // accepting edge.
    recv_val <= 1'b0;
    send_rdy <= 1'b0;
    cycles = 0;
    @(posedge clk);
    while (!send_val) begin
      check_value(recv_rdy ? 1.0 : 0.0, 0.0, 0.0,
                  $sformatf("case %0d recv_rdy while computing", c));
      cycles++;
      @(posedge clk);
    end
    check_value(real'(cycles), real'(log_n), 0.0, $sformatf("case %0d latency", c));
    compute_reference(c);
    for (int k = 0; k < n_samples; k++) begin
      held_re[k] = send_re[k];
      held_im[k] = send_im[k];
      check_value($itor(send_re[k]) * lsb, exp_re[k], tol,
                  $sformatf("case %0d bin %0d re", c, k));
      check_value($itor(send_im[k]) * lsb, exp_im[k], tol,
                  $sformatf("case %0d bin %0d im", c, k));
    end
    for (int h = 0; h < hold_off[c]; h++) begin
      @(posedge clk);
      check_value(send_val ? 1.0 : 0.0, 1.0, 0.0, $sformatf("case %0d send_val held", c));
      for (int k = 0; k < n_samples; k++) begin
        check_value($itor(send_re[k]), $itor(held_re[k]), 0.0,
                    $sformatf("case %0d bin %0d re held", c, k));
        check_value($itor(send_im[k]), $itor(held_im[k]), 0.0,
                    $sformatf("case %0d bin %0d im held", c, k));
      end
    end
    send_rdy <= 1'b1;                            // release edge.
    offered = 1'b0;
    if (hold_off[c] > 0 && c + 1 < n_cases) begin
      offer_frame(c + 1);                        // taken on the leaving edge.
      offered = 1'b1;
    end else begin
      @(posedge clk);
      send_rdy <= 1'b0;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    reset = 1'b1;
    recv_val = 1'b0;
    send_rdy = 1'b0;
    for (int i = 0; i < n_samples; i++) begin
      recv_re[i] = '0;
      recv_im[i] = '0;
    end
    seed = 32'hda47f2f3;
    offered = 1'b0;
    prepare_frames();
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_value(recv_rdy ? 1.0 : 0.0, 1.0, 0.0, "recv_rdy after reset");
    check_value(send_val ? 1.0 : 0.0, 0.0, 0.0, "send_val after reset");
    for (int k = 0; k < n_samples; k++) begin
      check_value($itor(send_re[k]), 0.0, 0.0, $sformatf("bank re %0d after reset", k));
      check_value($itor(send_im[k]), 0.0, 0.0, $sformatf("bank im %0d after reset", k));
    end
    for (int c = 0; c < n_cases; c++) begin
      if (!offered) begin
        @(posedge clk);
        check_value(send_val ? 1.0 : 0.0, 0.0, 0.0, $sformatf("case %0d idle send_val", c));
        check_value(recv_rdy ? 1.0 : 0.0, 1.0, 0.0, $sformatf("case %0d idle recv_rdy", c));
        offer_frame(c);
      end
      run_case(c);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin
    int longest;
    int limit;
    longest = 0;
    for (int c = 0; c < n_cases; c++) begin
      if (hold_off[c] > longest) longest = hold_off[c];
    end
    limit = n_cases * (log_n + 1 + longest + 4) + 20;
    repeat (limit) @(posedge clk);
    $display("TIMEOUT: the DUT stopped responding, no finished run after %0d cycles", limit);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: fft_pease.f
+incdir+.
fft_pkg.sv
fft_twiddle_rom.sv
fft_butterfly.sv
fft_stage_exec.sv
fft_sequencer.sv
fft_sample_bank.sv
fft_pease_top.sv
fft_tb.sv

// File: Makefile
# tool and build settings, all can be overridden on the command line
VERILATOR ?= verilator
TOP       ?= fft_tb
FILELIST  ?= fft_pease.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation finished: PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
